/* sources.f */
src/ssi_link_pkg.sv
src/ssi_ctrl_pkg.sv
src/ssi_tx_fifo.sv
src/ssi_tx_serializer.sv
src/ssi_rx_deserializer.sv
src/ssi_loopback_top.sv
tb/ssi_clk_gen.sv
tb/ssi_loopback_tb.sv

/* Makefile */
# Verilator build and run of the SSI loopback testbench

TOP := ssi_loopback_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f sources.f

run: compile
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* tb/ssi_loopback_tb.sv */
// SSI loopback testbench
// Writes samples into the transmit FIFO, loops the lanes back or injects
// framing faults, and checks received samples and status flags against a
// cycle model of the link built from its timing rules

`default_nettype none
`timescale 1ns/10ps

module ssi_loopback_tb;

  import ssi_link_pkg::*;
  import ssi_ctrl_pkg::*;

  localparam int FIFO_DEPTH = 8;
  localparam int DRIVE_DLY  = 5;
  localparam int LAST_BIT   = SSI_SAMPLE_W - 1;

  logic         ssi_clk;
  logic         arst_n;
  logic         mssi_sync;
  logic         tx_output_enable;
  logic         tx_valid;
  iq_sample_t   tx_sample;
  logic         tx_full;
  logic         tx_idata;
  logic         tx_qdata;
  logic         tx_strobe;
  logic         rx_idata;
  logic         rx_qdata;
  logic         rx_strobe;
  logic         rx_valid;
  iq_sample_t   rx_sample;
  link_status_t link_status;

  // Lane multiplexer selects the loopback or the injected fault pattern
  logic loop_en;
  logic inj_idata;
  logic inj_qdata;
  logic inj_strobe;

  // Link model state holds the FIFO fill and the serializer bit position per edge
  iq_sample_t exp_q[$];
  int         m_cnt       = 0;
  int         m_bit       = 0;
  bit         m_busy      = 1'b0;
  bit         m_req       = 1'b0;
  bit         m_ovf       = 1'b0;
  bit         m_ferr      = 1'b0;
  bit         m_urun      = 1'b0;
  int         cyc_num     = 0;
  int         rx_count    = 0;
  int         valid_cyc[$];
  int         error_count = 0;

  ssi_clk_gen clk0 (
    .ssi_clk (ssi_clk),
    .arst_n  (arst_n)
  );

  ssi_loopback_top #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) dut0 (
    .ssi_clk          (ssi_clk),
    .arst_n           (arst_n),
    .mssi_sync        (mssi_sync),
    .tx_output_enable (tx_output_enable),
    .tx_valid         (tx_valid),
    .tx_sample        (tx_sample),
    .tx_full          (tx_full),
    .tx_idata         (tx_idata),
    .tx_qdata         (tx_qdata),
    .tx_strobe        (tx_strobe),
    .rx_idata         (rx_idata),
    .rx_qdata         (rx_qdata),
    .rx_strobe        (rx_strobe),
    .rx_valid         (rx_valid),
    .rx_sample        (rx_sample),
    .link_status      (link_status)
  );

  // The loopback is combinational, so a sample lands 16 cycles after its strobe
  assign rx_idata  = loop_en ? tx_idata  : inj_idata;
  assign rx_qdata  = loop_en ? tx_qdata  : inj_qdata;
  assign rx_strobe = loop_en ? tx_strobe : inj_strobe;

  // ************************************************************
  // Reference model
  // ************************************************************

  // A write is taken while fewer than FIFO_DEPTH samples wait, or when the
  // head leaves on the same edge
  function automatic bit fifo_accepts(int held, bit popping);
    return (held < FIFO_DEPTH) || popping;
  endfunction

  function automatic link_status_t expected_status();
    link_status_t s;
    s.tx_overflow  = m_ovf;
    s.rx_frame_err = m_ferr;
    s.tx_underrun  = m_urun;
    return s;
  endfunction

  task automatic model_edge();
    bit pop;
    bit take;
    bit req_nxt;
    if (!arst_n || mssi_sync) begin
      exp_q.delete();
      m_cnt  = 0;
      m_bit  = 0;
      m_busy = 1'b0;
      m_req  = 1'b0;
      m_ovf  = 1'b0;
      m_ferr = 1'b0;
      m_urun = 1'b0;
    end else begin
      // Pop one cycle after idle sees data, or on the last bit of a sample
      pop     = m_req || (m_busy && (m_bit == LAST_BIT) && (m_cnt > 0));
      take    = tx_valid && fifo_accepts(m_cnt, pop);
      req_nxt = !m_busy && !m_req && (m_cnt > 0);
      if (take) begin
        exp_q.push_back(tx_sample);
      end
      if (tx_valid && !take) begin
        m_ovf = 1'b1;
      end
      m_cnt = m_cnt + int'(take) - int'(pop);
      if (pop) begin
        m_busy = 1'b1;
        m_bit  = 0;
      end else if (m_busy && (m_bit < LAST_BIT)) begin
        m_bit++;
      end else if (m_busy) begin
        // Stream broke with nothing queued
        m_busy = 1'b0;
        m_urun = 1'b1;
      end
      m_req = req_nxt;
    end
  endtask

  initial begin
    forever begin
      @(posedge ssi_clk);
      cyc_num++;
      model_edge();
    end
  end

  // ************************************************************
  // Checks and failure handling
  // ************************************************************

  task automatic end_with_failure();
    $display("Finished with errors");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic report_error(string msg);
    error_count++;
    $display("ERROR at %0t ns: %s", $time, msg);
    end_with_failure();
  endtask

  task automatic give_up(string what);
    $display("Timed out waiting for %s", what);
    end_with_failure();
  endtask

  task automatic check_sample(iq_sample_t got, iq_sample_t exp, string what);
    if (got !== exp) begin
      report_error($sformatf("%s i=%h q=%h, expected i=%h q=%h",
                             what, got.i, got.q, exp.i, exp.q));
    end
  endtask

  task automatic check_status(link_status_t got, link_status_t exp, string what);
    if (got !== exp) begin
      report_error($sformatf("%s ovf/ferr/urun=%b%b%b, expected %b%b%b", what,
                             got.tx_overflow, got.rx_frame_err, got.tx_underrun,
                             exp.tx_overflow, exp.rx_frame_err, exp.tx_underrun));
    end
  endtask

  task automatic check_level(logic got, logic exp, string what);
    if (got !== exp) begin
      report_error($sformatf("%s is %b, expected %b", what, got, exp));
    end
  endtask

  // Every received word is matched against the oldest accepted sample
  initial begin
    forever begin
      @(negedge ssi_clk);
      if (arst_n && rx_valid) begin
        if (exp_q.size() == 0) begin
          report_error("rx_valid with no sample expected");
        end else begin
          check_sample(rx_sample, exp_q.pop_front(), "rx_sample");
        end
        rx_count++;
        valid_cyc.push_back(cyc_num);
      end
    end
  end

  // ************************************************************
  // Stimulus helpers
  // ************************************************************

  task automatic next_drive_point();
    @(posedge ssi_clk);
    #(DRIVE_DLY);
  endtask

  task automatic write_samples(int n);
    for (int k = 0; k < n; k++) begin
      next_drive_point();
      tx_valid  = 1'b1;
      tx_sample = iq_sample_t'($urandom);
    end
    next_drive_point();
    tx_valid = 1'b0;
  endtask

  task automatic pulse_sync();
    next_drive_point();
    mssi_sync = 1'b1;
    next_drive_point();
    mssi_sync = 1'b0;
    @(negedge ssi_clk);
    check_status(link_status, expected_status(), "link_status after sync");
  endtask

  task automatic wait_reset(int limit);
    int n;
    n = 0;
    while (arst_n !== 1'b1) begin
      @(posedge ssi_clk);
      n++;
      if (n > limit) begin
        give_up("reset release");
      end
    end
  endtask

  // The receive count moves on the falling edge, so poll on the rising one
  task automatic wait_rx(int target, int limit, string what);
    int n;
    n = 0;
    while (rx_count < target) begin
      @(posedge ssi_clk);
      n++;
      if (n > limit) begin
        give_up(what);
      end
    end
  endtask

  task automatic wait_idle(int limit, string what);
    int n;
    n = 0;
    while (m_busy || m_req || (m_cnt > 0)) begin
      @(negedge ssi_clk);
      n++;
      if (n > limit) begin
        give_up(what);
      end
    end
  endtask

  task automatic expect_quiet(int cycles, string what);
    repeat (cycles) begin
      @(negedge ssi_clk);
      check_level(rx_valid, 1'b0, {"rx_valid ", what});
      check_level(tx_strobe, 1'b0, {"tx_strobe ", what});
      check_level(tx_idata, 1'b0, {"tx_idata ", what});
      check_level(tx_qdata, 1'b0, {"tx_qdata ", what});
    end
  endtask

  // Opens a word, cuts it short with a second strobe five cycles later,
  // then sends the full known word behind that strobe
  task automatic inject_framing_fault(iq_sample_t word);
    next_drive_point();
    inj_strobe = 1'b1;
    inj_idata  = 1'b1;
    inj_qdata  = 1'b0;
    repeat (4) begin
      next_drive_point();
      inj_strobe = 1'b0;
      inj_idata  = ~inj_idata;
      inj_qdata  = ~inj_qdata;
    end
    for (int b = LAST_BIT; b >= 0; b--) begin
      next_drive_point();
      inj_strobe = (b == LAST_BIT);
      inj_idata  = word.i[b];
      inj_qdata  = word.q[b];
    end
    next_drive_point();
    inj_strobe = 1'b0;
    inj_idata  = 1'b0;
    inj_qdata  = 1'b0;
  endtask

  // ************************************************************
  // Test sequence
  // ************************************************************

  initial begin
    int         base;
    int         gap;
    int         vb;
    int         n_acc;
    iq_sample_t word;
    void'($urandom(45));
    loop_en          = 1'b1;
    inj_idata        = 1'b0;
    inj_qdata        = 1'b0;
    inj_strobe       = 1'b0;
    mssi_sync        = 1'b0;
    tx_output_enable = 1'b1;
    tx_valid         = 1'b0;
    tx_sample        = '0;
    wait_reset(10);
    @(negedge ssi_clk);
    check_level(tx_full, 1'b0, "tx_full after reset");
    check_level(tx_strobe, 1'b0, "tx_strobe after reset");
    check_level(rx_valid, 1'b0, "rx_valid after reset");
    check_status(link_status, link_status_t'(0), "link_status after reset");

    // 1. Isolated samples through the loopback, in order
    base = rx_count;
    for (int s = 0; s < 40; s++) begin
      write_samples(1);
      gap = $urandom_range(40, 16);
      repeat (gap) @(posedge ssi_clk);
    end
    wait_rx(base + 40, 100, "the last loopback sample");
    wait_idle(40, "the serializer to go idle");
    check_status(link_status, expected_status(), "link_status after loopback run");

    // 2. A full burst goes out back to back
    pulse_sync();
    base = rx_count;
    vb   = valid_cyc.size();
    write_samples(FIFO_DEPTH);
    @(negedge ssi_clk);
    check_level(tx_full, (m_cnt == FIFO_DEPTH), "tx_full after burst");
    wait_rx(base + FIFO_DEPTH, FIFO_DEPTH * SSI_SAMPLE_W + 40, "the burst");
    for (int i = 1; i < FIFO_DEPTH; i++) begin
      check_level((valid_cyc[vb + i] - valid_cyc[vb + i - 1]) == SSI_SAMPLE_W, 1'b1,
                  "rx_valid spacing of 16 cycles");
    end

    // 3. Overflow, then sync throws away what is still in flight
    pulse_sync();
    base = rx_count;
    write_samples(FIFO_DEPTH + 3);
    @(negedge ssi_clk);
    n_acc = exp_q.size();
    check_level(tx_full, (m_cnt == FIFO_DEPTH), "tx_full after overflow burst");
    check_level(link_status.tx_overflow, 1'b1, "tx_overflow");
    check_status(link_status, expected_status(), "link_status after overflow");
    wait_rx(base + n_acc - 2, n_acc * SSI_SAMPLE_W + 40, "accepted overflow samples");
    pulse_sync();
    expect_quiet(40, "after sync");

    // 4. A strobe in the middle of a word
    next_drive_point();
    loop_en = 1'b0;
    word    = iq_sample_t'($urandom);
    exp_q.push_back(word);
    base = rx_count;
    inject_framing_fault(word);
    m_ferr = 1'b1;
    wait_rx(base + 1, 40, "the word behind the second strobe");
    @(negedge ssi_clk);
    check_level(link_status.rx_frame_err, 1'b1, "rx_frame_err");
    check_status(link_status, expected_status(), "link_status after framing fault");
    next_drive_point();
    loop_en = 1'b1;
    pulse_sync();

    // 5. Lanes silenced by the output enable
    next_drive_point();
    tx_output_enable = 1'b0;
    base = rx_count;
    write_samples(1);
    expect_quiet(40, "with output enable low");
    wait_idle(40, "the serializer to go idle");
    check_level(link_status.tx_underrun, 1'b1, "tx_underrun");
    check_level(rx_count == base, 1'b1, "no sample received");
    next_drive_point();
    tx_output_enable = 1'b1;
    pulse_sync();

    if (error_count == 0) begin
      $display("Finished with no errors");
      $finish;
    end else begin
      end_with_failure();
    end
  end

endmodule

`default_nettype wire

/* tb/ssi_clk_gen.sv */
// SSI testbench clock and reset source
// Free running ssi_clk with a 100 ns period and an active low reset
// held for the first two rising edges

`default_nettype none
`timescale 1ns/10ps

module ssi_clk_gen #(
  parameter int HALF_PERIOD_NS = 50,
  parameter int RESET_CYCLES   = 2
) (
  output logic ssi_clk,
  output logic arst_n
);

  initial begin
    ssi_clk = 1'b0;
    forever #(HALF_PERIOD_NS) ssi_clk = ~ssi_clk;
  end

  // Release lines up with the stimulus point after the second edge
  initial begin
    arst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge ssi_clk);
    #5 arst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* src/ssi_loopback_top.sv */
// SSI single channel loopback top
// Transmit FIFO and serializer drive the outgoing lanes, gated by the
// output enable. The deserializer rebuilds samples from the incoming lanes.
// The sticky flags of all three blocks are packed into one status word

`default_nettype none
`timescale 1ns/10ps

module ssi_loopback_top #(
  parameter int FIFO_DEPTH = 8
) (
  input  wire                         ssi_clk,
  input  wire                         arst_n,
  input  wire                         mssi_sync,
  input  wire                         tx_output_enable,
  input  wire                         tx_valid,
  input  wire ssi_link_pkg::iq_sample_t tx_sample,
  output logic                        tx_full,
  output logic                        tx_idata,
  output logic                        tx_qdata,
  output logic                        tx_strobe,
  input  wire                         rx_idata,
  input  wire                         rx_qdata,
  input  wire                         rx_strobe,
  output logic                        rx_valid,
  output ssi_link_pkg::iq_sample_t    rx_sample,
  output ssi_ctrl_pkg::link_status_t  link_status
);

  import ssi_link_pkg::*;

  iq_sample_t fifo_data;
  logic       fifo_empty;
  logic       fifo_pop;
  logic       ser_idata;
  logic       ser_qdata;
  logic       ser_strobe;
  logic       tx_overflow;
  logic       tx_underrun;
  logic       rx_frame_err;

  // **********************************************************
  // Transmit path
  // **********************************************************

  ssi_tx_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) fifo0 (
    .ssi_clk     (ssi_clk),
    .arst_n      (arst_n),
    .mssi_sync   (mssi_sync),
    .tx_valid    (tx_valid),
    .tx_sample   (tx_sample),
    .fifo_pop    (fifo_pop),
    .fifo_data   (fifo_data),
    .fifo_empty  (fifo_empty),
    .tx_full     (tx_full),
    .tx_overflow (tx_overflow)
  );

  ssi_tx_serializer ser0 (
    .ssi_clk     (ssi_clk),
    .arst_n      (arst_n),
    .mssi_sync   (mssi_sync),
    .fifo_empty  (fifo_empty),
    .fifo_data   (fifo_data),
    .fifo_pop    (fifo_pop),
    .tx_idata    (ser_idata),
    .tx_qdata    (ser_qdata),
    .tx_strobe   (ser_strobe),
    .tx_underrun (tx_underrun)
  );

  // Serializer keeps running with the enable low, only the lanes go quiet
  assign tx_idata  = ser_idata & tx_output_enable;
  assign tx_qdata  = ser_qdata & tx_output_enable;
  assign tx_strobe = ser_strobe & tx_output_enable;

  // **********************************************************
  // Receive path
  // **********************************************************

  ssi_rx_deserializer des0 (
    .ssi_clk      (ssi_clk),
    .arst_n       (arst_n),
    .mssi_sync    (mssi_sync),
    .rx_idata     (rx_idata),
    .rx_qdata     (rx_qdata),
    .rx_strobe    (rx_strobe),
    .rx_valid     (rx_valid),
    .rx_sample    (rx_sample),
    .rx_frame_err (rx_frame_err)
  );

  // Status word collects the sticky flags of both directions
  assign link_status.tx_overflow  = tx_overflow;
  assign link_status.rx_frame_err = rx_frame_err;
  assign link_status.tx_underrun  = tx_underrun;

endmodule

`default_nettype wire

/* src/ssi_rx_deserializer.sv */
// SSI receive deserializer
// Frames the incoming I and Q lane bits by the strobe lane, rebuilds each
// sample and presents it with a one-cycle valid. A strobe in the middle of
// a word is a framing error and restarts the word from that strobe

`default_nettype none
`timescale 1ns/10ps

module ssi_rx_deserializer (
  input  wire                      ssi_clk,
  input  wire                      arst_n,
  input  wire                      mssi_sync,
  input  wire                      rx_idata,
  input  wire                      rx_qdata,
  input  wire                      rx_strobe,
  output logic                     rx_valid,
  output ssi_link_pkg::iq_sample_t rx_sample,
  output logic                     rx_frame_err
);

  import ssi_link_pkg::*;
  import ssi_ctrl_pkg::*;

  localparam int              CNT_W    = $clog2(SSI_SAMPLE_W);
  localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(SSI_SAMPLE_W - 1);

  des_state_t              state;
  logic [SSI_SAMPLE_W-2:0] hist_i;
  logic [SSI_SAMPLE_W-2:0] hist_q;
  logic [CNT_W-1:0]        bit_cnt;
  logic                    word_done;

  // **********************************************************
  // Lane history
  // **********************************************************

  // The lanes are shifted in on every edge whatever the state.
  // When bit 0 arrives the history holds bits 15 to 1 of the same word,
  // so no separate load is needed at the strobe
  always_ff @(posedge ssi_clk) begin
    hist_i <= {hist_i[SSI_SAMPLE_W-3:0], rx_idata};
    hist_q <= {hist_q[SSI_SAMPLE_W-3:0], rx_qdata};
  end

  // Bit 0 is on the lanes now and no new strobe cuts the word short
  assign word_done = (state == DES_SHIFT) && !rx_strobe && (bit_cnt == LAST_BIT) &&
                     !mssi_sync;

  // **********************************************************
  // Framing FSM
  // **********************************************************

  // Counter holds the number of bits captured so far in the current word
  always_ff @(posedge ssi_clk or negedge arst_n) begin
    if (!arst_n) begin
      state        <= DES_HUNT;
      bit_cnt      <= '0;
      rx_valid     <= 1'b0;
      rx_frame_err <= 1'b0;
    end else if (mssi_sync) begin
      state        <= DES_HUNT;
      bit_cnt      <= '0;
      rx_valid     <= 1'b0;
      rx_frame_err <= 1'b0;
    end else begin
      rx_valid <= word_done;
      if (rx_strobe) begin
        // Strobe edge captures bit 15; mid-word it drops the partial word
        if (state == DES_SHIFT) begin
          rx_frame_err <= 1'b1;
        end
        state   <= DES_SHIFT;
        bit_cnt <= CNT_W'(1);
      end else if (state == DES_SHIFT) begin
        if (bit_cnt == LAST_BIT) begin
          state <= DES_HUNT;
        end
        bit_cnt <= bit_cnt + CNT_W'(1);
      end
    end
  end

  // Sample holds its value until the next complete word
  always_ff @(posedge ssi_clk) begin
    if (word_done) begin
      rx_sample.i <= {hist_i, rx_idata};
      rx_sample.q <= {hist_q, rx_qdata};
    end
  end

  // **********************************************************
  // Checks
  // **********************************************************

  // Words take 16 cycles, so two valids can never be adjacent
  a_valid_single : assert property (
    @(posedge ssi_clk) disable iff (!arst_n) rx_valid |=> !rx_valid
  );

endmodule

`default_nettype wire

/* src/ssi_tx_serializer.sv */
// SSI transmit serializer
// Pops samples from the transmit FIFO and shifts I and Q out MSB first on
// two lanes, with the strobe lane high during the first bit of each sample.
// Samples follow back to back while the FIFO holds data

`default_nettype none
`timescale 1ns/10ps

module ssi_tx_serializer (
  input  wire                        ssi_clk,
  input  wire                        arst_n,
  input  wire                        mssi_sync,
  input  wire                        fifo_empty,
  input  wire ssi_link_pkg::iq_sample_t fifo_data,
  output logic                       fifo_pop,
  output logic                       tx_idata,
  output logic                       tx_qdata,
  output logic                       tx_strobe,
  output logic                       tx_underrun
);

  import ssi_link_pkg::*;
  import ssi_ctrl_pkg::*;

  localparam int              CNT_W    = $clog2(SSI_SAMPLE_W);
  localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(SSI_SAMPLE_W - 1);

  ser_state_t              state;
  logic [SSI_SAMPLE_W-1:0] shift_i;
  logic [SSI_SAMPLE_W-1:0] shift_q;
  logic [CNT_W-1:0]        bit_cnt;
  logic                    pop_req;
  logic                    last_bit;

  // Bit counter holds the index of the bit now on the lanes, 0 being bit 15
  assign last_bit = (state == SER_SHIFT) && (bit_cnt == LAST_BIT);

  // From idle the pop is a registered request, one cycle after data shows up.
  // On the last bit the pop is taken straight from fifo_empty so the next
  // strobe lands right after bit 0
  assign fifo_pop = pop_req || (last_bit && !fifo_empty);

  // Lanes come straight off the top of the shift registers
  assign tx_idata = shift_i[SSI_SAMPLE_W-1];
  assign tx_qdata = shift_q[SSI_SAMPLE_W-1];

  // **********************************************************
  // Shift FSM
  // **********************************************************

  always_ff @(posedge ssi_clk or negedge arst_n) begin
    if (!arst_n) begin
      state       <= SER_IDLE;
      pop_req     <= 1'b0;
      bit_cnt     <= '0;
      shift_i     <= '0;
      shift_q     <= '0;
      tx_strobe   <= 1'b0;
      tx_underrun <= 1'b0;
    end else if (mssi_sync) begin
      state       <= SER_IDLE;
      pop_req     <= 1'b0;
      bit_cnt     <= '0;
      shift_i     <= '0;
      shift_q     <= '0;
      tx_strobe   <= 1'b0;
      tx_underrun <= 1'b0;
    end else begin
      // Request a pop once per idle period
      pop_req <= (state == SER_IDLE) && !pop_req && !fifo_empty;

      if (fifo_pop) begin
        // Load the head and put bit 15 out with the strobe
        state     <= SER_SHIFT;
        shift_i   <= fifo_data.i;
        shift_q   <= fifo_data.q;
        bit_cnt   <= '0;
        tx_strobe <= 1'b1;
      end else if ((state == SER_SHIFT) && !last_bit) begin
        shift_i   <= {shift_i[SSI_SAMPLE_W-2:0], 1'b0};
        shift_q   <= {shift_q[SSI_SAMPLE_W-2:0], 1'b0};
        bit_cnt   <= bit_cnt + CNT_W'(1);
        tx_strobe <= 1'b0;
      end else if (state == SER_SHIFT) begin
        // Nothing queued behind this sample, so the stream breaks here.
        // Being in SER_SHIFT already means a sample went out since sync
        state       <= SER_IDLE;
        shift_i     <= '0;
        shift_q     <= '0;
        tx_strobe   <= 1'b0;
        tx_underrun <= 1'b1;
      end
    end
  end

  // **********************************************************
  // Checks
  // **********************************************************

  // Each strobe marks one 16-bit sample, so it never repeats on the next cycle
  a_strobe_single : assert property (
    @(posedge ssi_clk) disable iff (!arst_n) tx_strobe |=> !tx_strobe
  );

  a_pop_window : assert property (
    @(posedge ssi_clk) disable iff (!arst_n)
      fifo_pop |-> ((state == SER_IDLE) || (bit_cnt == LAST_BIT))
  );

endmodule

`default_nettype wire

/* src/ssi_tx_fifo.sv */
// SSI transmit sample FIFO
// Circular buffer between the parallel sample strobe and the serializer.
// Writes made while full are dropped and flagged in a sticky overflow bit

`default_nettype none
`timescale 1ns/10ps

module ssi_tx_fifo #(
  parameter int FIFO_DEPTH = 8
) (
  input  wire                        ssi_clk,
  input  wire                        arst_n,
  input  wire                        mssi_sync,
  input  wire                        tx_valid,
  input  wire ssi_link_pkg::iq_sample_t tx_sample,
  input  wire                        fifo_pop,
  output ssi_link_pkg::iq_sample_t   fifo_data,
  output logic                       fifo_empty,
  output logic                       tx_full,
  output logic                       tx_overflow
);

  import ssi_link_pkg::*;

  // A depth of one still needs a one bit address, so the floor is 1
  localparam int ADDR_W    = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int PTR_W     = ADDR_W + 1;
  localparam int MEM_DEPTH = 2 ** ADDR_W;

  iq_sample_t       mem [MEM_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W-1:0] wr_ptr_nxt;
  logic [PTR_W-1:0] rd_ptr_nxt;
  logic [PTR_W-1:0] fill_nxt;
  logic             wr_en;
  logic             full_nxt;

  // A write goes in if there is room, or if the head leaves on the same edge
  assign wr_en = tx_valid && (!tx_full || fifo_pop);

  always_comb begin
    wr_ptr_nxt = wr_ptr + PTR_W'(wr_en);
    rd_ptr_nxt = rd_ptr + PTR_W'(fifo_pop);
    fill_nxt   = wr_ptr_nxt - rd_ptr_nxt;
    full_nxt   = (fill_nxt == PTR_W'(FIFO_DEPTH));
  end

  // Pointers carry one wrap bit above the address
  always_ff @(posedge ssi_clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      tx_full     <= 1'b0;
      tx_overflow <= 1'b0;
    end else if (mssi_sync) begin
      // Sync flushes whatever is still waiting to go out
      wr_ptr      <= '0;
      rd_ptr      <= '0;
      tx_full     <= 1'b0;
      tx_overflow <= 1'b0;
    end else begin
      wr_ptr  <= wr_ptr_nxt;
      rd_ptr  <= rd_ptr_nxt;
      tx_full <= full_nxt;
      if (tx_valid && !wr_en) begin
        tx_overflow <= 1'b1;
      end
    end
  end

  always_ff @(posedge ssi_clk) begin
    if (wr_en) begin
      mem[wr_ptr[ADDR_W-1:0]] <= tx_sample;
    end
  end

  // Head of the queue is always presented to the serializer
  assign fifo_data  = mem[rd_ptr[ADDR_W-1:0]];
  assign fifo_empty = (wr_ptr == rd_ptr);

  // **********************************************************
  // Checks
  // **********************************************************

  // The serializer must only pop a sample that is there
  a_no_pop_empty : assert property (
    @(posedge ssi_clk) disable iff (!arst_n) fifo_pop |-> !fifo_empty
  );

  a_depth_pow2 : assert property (
    @(posedge ssi_clk) (FIFO_DEPTH > 0) && ((FIFO_DEPTH & (FIFO_DEPTH - 1)) == 0)
  );

endmodule

`default_nettype wire

/* src/ssi_ctrl_pkg.sv */
// SSI link control definitions
// FSM encodings of the serializer and deserializer, and the link status word

`default_nettype none

package ssi_ctrl_pkg;

  // Transmit FSM is either idle with the lanes at 0 or shifting a sample out
  typedef enum logic {
    SER_IDLE  = 1'b0,
    SER_SHIFT = 1'b1
  } ser_state_t;

  // Receive FSM is either hunting for a strobe or collecting the bits of a word
  typedef enum logic {
    DES_HUNT  = 1'b0,
    DES_SHIFT = 1'b1
  } des_state_t;

  // Sticky error flags that mssi_sync clears
  typedef struct packed {
    logic tx_overflow;
    logic rx_frame_err;
    logic tx_underrun;
  } link_status_t;

endpackage

`default_nettype wire

/* src/ssi_link_pkg.sv */
// SSI link payload definitions
// Sample width and the complex I/Q sample carried over one SSI channel

`default_nettype none

package ssi_link_pkg;

  // **********************************************************
  // Sample format
  // **********************************************************

  // Bits per I or Q word, and so the number of lane cycles per sample
  localparam int SSI_SAMPLE_W = 16;

  // One complex baseband sample
  // The I word rides on the idata lane and the Q word on the qdata lane
  typedef struct packed {
    logic [SSI_SAMPLE_W-1:0] i;
    logic [SSI_SAMPLE_W-1:0] q;
  } iq_sample_t;

endpackage

`default_nettype wire
